// File: hdl/ql_bus_config.svh
//================================================
// QL bus glue configuration
// Bus widths, address masks per RAM size and the
// GoldCard / QL-SD register offsets
//================================================
`ifndef QL_BUS_CONFIG_SVH
`define QL_BUS_CONFIG_SVH

// 68008 bus as seen by the glue
`define QL_ADDR_W 24             // Byte address width
`define QL_DATA_W 16             // Word data path

//================================================
// Address wrap masks
//================================================
`define QL_MASK_128K 24'h03FFFF  // 128k RAM, wraps at 256 KB
`define QL_MASK_1M   24'h0FFFFF  // 640k and 896k, wraps at 1 MB
`define QL_MASK_8M   24'h7FFFFF  // 4 MB RAM plus GoldCard spaces

// GoldCard I/O register offsets, low address byte
`define QL_GC_SHADOW_ON  8'h60   // glo_rena
`define QL_GC_SHADOW_OFF 8'h64   // glo_rdis

// Only QL-SD register that returns data
`define QL_QLSD_RD_ADDR 16'hFEE4

// VRAM sits in the $02xxxx page
`define QL_VRAM_PAGE 8'h02

// Open bus pattern
`define QL_UNMAPPED_DATA 16'hFFFF

`endif

// File: hdl/ql_bus_pkg.sv
//================================================
// QL bus glue types
// RAM size setting and decoded bus regions
//================================================
package ql_bus_pkg;

	// Installed RAM, 4096k also selects GoldCard mode
	typedef enum logic [1:0]
	{
		ram_128k  = 2'd0,
		ram_640k  = 2'd1,
		ram_896k  = 2'd2,
		ram_4096k = 2'd3
	} ram_cfg_e;

	//================================================
	// One region per bus cycle
	//================================================
	typedef enum logic [3:0]
	{
		reg_none        = 4'd0,  // Nothing mapped
		reg_os_rom      = 4'd1,  // $0000-$BFFF
		reg_ext_rom     = 4'd2,  // $C000-$FFFF
		reg_qlsd_data   = 4'd3,  // $FFxx, QL-SD data page
		reg_qlsd_reg    = 4'd4,  // $FEE4 readable register
		reg_ql_io       = 4'd5,  // $18000-$1BFFF
		reg_gc_io       = 4'd6,  // $1C000-$1C0FF
		reg_ram         = 4'd7,  // Base, extended or GoldCard RAM
		reg_gc_boot_rom = 4'd8,  // $040000-$04FFFF
		reg_gc_os_rom   = 4'd9   // $400000-$40FFFF
	} bus_region_e;

	// Other $FEEx/$FEFx addresses only raise qlsd_sel
	// and read as EXT ROM

endpackage

// File: hdl/ql_addr_decode.sv
//================================================
// QL address decoder
// Latches RAM size in reset, masks the CPU address
// and classifies each bus cycle into one region
//================================================
`timescale 1ns/1ps
`include "ql_bus_config.svh"

module ql_addr_decode
(
	input  logic                     clk_sys,
	input  logic                     reset,
	input  ql_bus_pkg::ram_cfg_e     ram_cfg_sel,  // Sampled while reset is high
	input  logic [`QL_ADDR_W-1:1]    cpu_addr_hi,
	input  logic                     cpu_as,
	input  logic                     cpu_rw,
	input  logic                     cpu_uds,
	input  logic                     cpu_lds,
	input  logic                     rom_shadow,   // Opens QL-SD in GoldCard mode
	output ql_bus_pkg::bus_region_e  region,
	output logic                     gc_mode,
	output logic                     cpu_rd,
	output logic                     cpu_wr,
	output logic                     io_sel,
	output logic                     qimi_sel,
	output logic                     zx8302_sel,
	output logic                     qlsd_sel,
	output logic                     gc_io_wr,
	output logic                     vram_wr,
	output logic [`QL_ADDR_W-1:0]    sdram_addr
);
	import ql_bus_pkg::*;

	ram_cfg_e              ram_cfg;
	logic [`QL_ADDR_W-1:0] addr_mask;
	logic [`QL_ADDR_W-1:0] addr;      // Masked byte address
	logic                  byte_lo;
	logic                  in_rom;
	logic                  in_ext_rom;
	logic                  in_ql_io;
	logic                  in_gc_io;
	logic                  in_bram;
	logic                  in_xram;
	logic                  in_gc_ram;
	logic                  in_ram;
	logic                  in_gc_boot;
	logic                  in_gc_os;
	logic                  qlsd_en;
	logic                  qlsd_rd;
	logic                  qlsd_dat;
	logic                  qlsd_page;

	// RAM size held from the end of reset
	always_ff @(posedge clk_sys)
	begin
		if (reset)
			ram_cfg <= ram_cfg_sel;
	end

	assign gc_mode = (ram_cfg == ram_4096k);

	always_comb
	begin
		case (ram_cfg)
			ram_128k:  addr_mask = `QL_MASK_128K;
			ram_640k,
			ram_896k:  addr_mask = `QL_MASK_1M;
			default:   addr_mask = `QL_MASK_8M;
		endcase
	end

	// Lower byte only when LDS alone is active
	assign byte_lo    = !cpu_uds && cpu_lds;
	assign addr       = {cpu_addr_hi, byte_lo} & addr_mask;
	assign sdram_addr = {3'b000, addr[21:1]};

	assign cpu_rd = cpu_as && cpu_rw && (cpu_uds || cpu_lds);
	assign cpu_wr = cpu_as && !cpu_rw && (cpu_uds || cpu_lds);

	//================================================
	// Address space pieces
	//================================================
	assign in_rom     = (addr[23:16] == 8'h00);             // 64k ROM window
	assign in_ext_rom = in_rom && (addr[15:14] == 2'b11);
	assign in_ql_io   = (addr[23:14] == 10'd6);             // $18000
	assign in_gc_io   = gc_mode && (addr[23:8] == 16'h01C0);
	assign in_bram    = (addr[23:17] == 7'd1);              // $20000-$3FFFF

	// Extended RAM by size
	always_comb
	begin
		case (ram_cfg)
			ram_640k:  in_xram = (addr[23:20] == 4'h0) && ^addr[19:18];
			ram_896k:  in_xram = (addr[23:20] == 4'h0) && |addr[19:18];
			ram_4096k: in_xram = (addr[23:22] == 2'b00) && |addr[21:18];
			default:   in_xram = 1'b0;
		endcase
	end

	// Extra GoldCard RAM at $10000 and $1C100
	assign in_gc_ram = gc_mode && ((addr[23:15] == 9'd2) ||
		((addr[23:14] == 10'd7) && !in_gc_io));
	assign in_ram     = in_bram || in_xram || in_gc_ram;
	assign in_gc_boot = gc_mode && !rom_shadow && (addr[23:16] == 8'h04); // Over 4M RAM
	assign in_gc_os   = gc_mode && (addr[23:16] == 8'h40);

	// QL-SD lives in the ROM window on reads
	assign qlsd_en   = (!gc_mode || rom_shadow) && cpu_rd && in_rom;
	assign qlsd_page = (addr[15:4] == 12'hFEE) || (addr[15:4] == 12'hFEF);
	assign qlsd_rd   = qlsd_en && (addr[15:0] == `QL_QLSD_RD_ADDR);
	assign qlsd_dat  = qlsd_en && (addr[15:8] == 8'hFF);
	assign qlsd_sel  = qlsd_en && (qlsd_page || (addr[15:8] == 8'hFF));

	// QL-SD wins over the ROM it overlays
	always_comb
	begin
		if (qlsd_rd)
			region = reg_qlsd_reg;
		else if (qlsd_dat)
			region = reg_qlsd_data;
		else if (in_ext_rom)
			region = reg_ext_rom;
		else if (in_rom)
			region = reg_os_rom;
		else if (in_ql_io)
			region = reg_ql_io;
		else if (in_gc_io)
			region = reg_gc_io;
		else if (in_gc_boot)
			region = reg_gc_boot_rom;
		else if (in_ram)
			region = reg_ram;
		else if (in_gc_os)
			region = reg_gc_os_rom;
		else
			region = reg_none;
	end

	// Peripheral selects with the mouse at $1BFxx
	assign io_sel     = (region == reg_ql_io) && (cpu_rd || cpu_wr);
	assign qimi_sel   = io_sel && (addr[13:8] == 6'h3F);
	assign zx8302_sel = io_sel && !addr[6] && !qimi_sel;
	assign gc_io_wr   = (region == reg_gc_io) && cpu_wr;
	assign vram_wr    = cpu_wr && (addr[23:16] == `QL_VRAM_PAGE);

	// No two peripheral selects share an address
	assert property (@(posedge clk_sys) disable iff (reset)
		$onehot0({qimi_sel, zx8302_sel, qlsd_sel, gc_io_wr, vram_wr}))
		else $error("more than one peripheral select active");

	assert property (@(posedge clk_sys) disable iff (reset)
		(region == reg_gc_io) |-> gc_mode)
		else $error("GoldCard I/O decoded outside GoldCard mode");

endmodule

// File: hdl/gc_shadow_ctrl.sv
//================================================
// GoldCard shadow RAM control
// Enable flag for the OS ROM shadow, set and
// cleared by writes to the GoldCard I/O page
//================================================
`timescale 1ns/1ps
`include "ql_bus_config.svh"

module gc_shadow_ctrl
(
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       gc_io_wr,     // Write into $1C000-$1C0FF
	input  logic       cpu_uds,
	input  logic       cpu_lds,
	input  logic [7:0] cpu_addr_lo,  // Offset inside the GC I/O page
	output logic       rom_shadow
);
	logic reg_wr;

	// Byte writes on the upper strobe only
	assign reg_wr = gc_io_wr && cpu_uds && !cpu_lds;

	//================================================
	// Shadow enable flag
	//================================================
	always_ff @(posedge clk_sys)
	begin
		if (reset)
			rom_shadow <= 1'b0;
		else if (reg_wr)
		begin
			if (cpu_addr_lo == `QL_GC_SHADOW_ON)
				rom_shadow <= 1'b1;          // glo_rena
			else if (cpu_addr_lo == `QL_GC_SHADOW_OFF)
				rom_shadow <= 1'b0;          // glo_rdis
		end
	end

	// Boot always starts from the GoldCard ROM
	assert property (@(posedge clk_sys) reset |=> !rom_shadow)
		else $error("rom_shadow set right after reset");

endmodule

// File: hdl/ql_read_steer.sv
//================================================
// QL read data and acknowledge steering
// Picks CPU read data per mode and region, drives
// SDRAM strobes and the data acknowledge
//================================================
`timescale 1ns/1ps
`include "ql_bus_config.svh"

module ql_read_steer
(
	input  ql_bus_pkg::bus_region_e  region,
	input  logic                     gc_mode,
	input  logic                     rom_shadow,
	input  logic                     cpu_rd,
	input  logic                     cpu_wr,
	input  logic                     io_sel,
	input  logic                     qimi_sel,
	input  logic                     zx8302_sel,
	input  logic                     qlsd_sel,
	input  logic [`QL_DATA_W-1:0]    ql_rom_data,
	input  logic [`QL_DATA_W-1:0]    gc_rom_data,
	input  logic [`QL_DATA_W-1:0]    sdram_data,
	input  logic [`QL_DATA_W-1:0]    io_data,     // Mouse byte in bits 7:0
	input  logic [7:0]               qlsd_data,
	input  logic                     sdram_dtack,
	input  logic                     qlsd_dtack,
	input  logic                     ram_delay_dtack,  // QL bus timing hold-off
	output logic [`QL_DATA_W-1:0]    cpu_din,
	output logic                     cpu_dtack,
	output logic                     sdram_wr,
	output logic                     sdram_oe
);
	import ql_bus_pkg::*;

	logic                  in_os_rom;
	logic                  in_ext_rom;
	logic                  in_ram;
	logic                  qlsd_rd;
	logic                  shadow_rd;
	logic                  shadow_wr;
	logic [`QL_DATA_W-1:0] io_dout;
	logic [`QL_DATA_W-1:0] ql_dout;
	logic [`QL_DATA_W-1:0] gc_boot_dout;
	logic [`QL_DATA_W-1:0] gc_shadow_dout;

	assign in_os_rom  = (region == reg_os_rom);
	assign in_ext_rom = (region == reg_ext_rom) || (region == reg_qlsd_data); // $FFxx is ROM too
	assign in_ram     = (region == reg_ram);
	assign qlsd_rd    = (region == reg_qlsd_reg);

	// Shadow qualifiers on the OS ROM range
	assign shadow_rd = cpu_rd && in_os_rom && rom_shadow;
	assign shadow_wr = cpu_wr && in_os_rom && !rom_shadow;  // Preload while off

	//================================================
	// Read data per mode
	//================================================
	assign io_dout = qimi_sel ? {io_data[7:0], io_data[7:0]} :
		zx8302_sel ? io_data : '0;

	// Plain QL
	assign ql_dout = qlsd_rd ? {qlsd_data, qlsd_data} :
		(in_os_rom || in_ext_rom) ? ql_rom_data :
		in_ram ? sdram_data : `QL_UNMAPPED_DATA;

	// GoldCard boot, GC ROM in both low windows
	assign gc_boot_dout = (in_os_rom || in_ext_rom) ? gc_rom_data :
		(region == reg_gc_boot_rom) ? gc_rom_data :
		(region == reg_gc_os_rom) ? ql_rom_data :
		in_ram ? sdram_data : `QL_UNMAPPED_DATA;

	// GoldCard with OS ROM copy in SDRAM
	assign gc_shadow_dout = in_os_rom ? sdram_data :
		qlsd_rd ? {qlsd_data, qlsd_data} :
		(in_ext_rom || (region == reg_gc_os_rom)) ? ql_rom_data :
		in_ram ? sdram_data : `QL_UNMAPPED_DATA;

	always_comb
	begin
		if (io_sel)
			cpu_din = io_dout;              // Internal I/O always mapped
		else if (!gc_mode)
			cpu_din = ql_dout;
		else if (rom_shadow)
			cpu_din = gc_shadow_dout;
		else
			cpu_din = gc_boot_dout;
	end

	// SDRAM strobes
	assign sdram_oe = (cpu_rd && in_ram) || shadow_rd;
	assign sdram_wr = (cpu_wr && in_ram) || shadow_wr;

	// Acknowledge priority
	always_comb
	begin
		if (qlsd_sel)
			cpu_dtack = qlsd_dtack;
		else if (shadow_rd || shadow_wr)
			cpu_dtack = sdram_dtack;        // Shadow runs at full speed
		else if (in_ram)
			cpu_dtack = sdram_dtack && !ram_delay_dtack;
		else
			cpu_dtack = !ram_delay_dtack;
	end

	always_comb
	begin
		assert (!(sdram_wr && sdram_oe))
			else $error("sdram_wr and sdram_oe both active");
	end

endmodule

// File: hdl/ql_bus_glue.sv
//================================================
// QL bus glue top
// Memory map decode, GoldCard shadow register and
// read steering for the 68008 bus
//================================================
`timescale 1ns/1ps
`include "ql_bus_config.svh"

module ql_bus_glue
(
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic [`QL_ADDR_W-1:1]  cpu_addr_hi,
	input  logic                   cpu_as,
	input  logic                   cpu_rw,
	input  logic                   cpu_uds,
	input  logic                   cpu_lds,
	input  logic [`QL_DATA_W-1:0]  cpu_dout,     // CPU write data
	input  ql_bus_pkg::ram_cfg_e   ram_cfg_sel,
	input  logic [`QL_DATA_W-1:0]  ql_rom_data,
	input  logic [`QL_DATA_W-1:0]  gc_rom_data,
	input  logic [`QL_DATA_W-1:0]  sdram_data,
	input  logic [`QL_DATA_W-1:0]  io_data,
	input  logic [7:0]             qlsd_data,
	input  logic                   sdram_dtack,
	input  logic                   qlsd_dtack,
	input  logic                   ram_delay_dtack,
	output logic [`QL_DATA_W-1:0]  cpu_din,
	output logic                   cpu_dtack,
	output logic [`QL_ADDR_W-1:0]  sdram_addr,
	output logic [`QL_DATA_W-1:0]  sdram_din,    // Shared write bus for SDRAM and VRAM
	output logic                   sdram_wr,
	output logic                   sdram_oe,
	output logic                   vram_wr,
	output logic                   rom_shadow,
	output logic                   io_sel,
	output logic                   qimi_sel,
	output logic                   zx8302_sel,
	output logic                   qlsd_sel
);
	import ql_bus_pkg::*;

	bus_region_e region;
	logic        gc_mode;
	logic        cpu_rd;
	logic        cpu_wr;
	logic        gc_io_wr;
	logic [7:0]  cpu_addr_lo;

	assign sdram_din = cpu_dout;

	// Byte bit is 0 for upper strobe writes, the only ones the register takes
	assign cpu_addr_lo = {cpu_addr_hi[7:1], 1'b0};

	ql_addr_decode u_decode
	(
		.clk_sys     (clk_sys),
		.reset       (reset),
		.ram_cfg_sel (ram_cfg_sel),
		.cpu_addr_hi (cpu_addr_hi),
		.cpu_as      (cpu_as),
		.cpu_rw      (cpu_rw),
		.cpu_uds     (cpu_uds),
		.cpu_lds     (cpu_lds),
		.rom_shadow  (rom_shadow),
		.region      (region),
		.gc_mode     (gc_mode),
		.cpu_rd      (cpu_rd),
		.cpu_wr      (cpu_wr),
		.io_sel      (io_sel),
		.qimi_sel    (qimi_sel),
		.zx8302_sel  (zx8302_sel),
		.qlsd_sel    (qlsd_sel),
		.gc_io_wr    (gc_io_wr),
		.vram_wr     (vram_wr),
		.sdram_addr  (sdram_addr)
	);

	gc_shadow_ctrl u_shadow
	(
		.clk_sys     (clk_sys),
		.reset       (reset),
		.gc_io_wr    (gc_io_wr),
		.cpu_uds     (cpu_uds),
		.cpu_lds     (cpu_lds),
		.cpu_addr_lo (cpu_addr_lo),
		.rom_shadow  (rom_shadow)
	);

	ql_read_steer u_steer
	(
		.region          (region),
		.gc_mode         (gc_mode),
		.rom_shadow      (rom_shadow),
		.cpu_rd          (cpu_rd),
		.cpu_wr          (cpu_wr),
		.io_sel          (io_sel),
		.qimi_sel        (qimi_sel),
		.zx8302_sel      (zx8302_sel),
		.qlsd_sel        (qlsd_sel),
		.ql_rom_data     (ql_rom_data),
		.gc_rom_data     (gc_rom_data),
		.sdram_data      (sdram_data),
		.io_data         (io_data),
		.qlsd_data       (qlsd_data),
		.sdram_dtack     (sdram_dtack),
		.qlsd_dtack      (qlsd_dtack),
		.ram_delay_dtack (ram_delay_dtack),
		.cpu_din         (cpu_din),
		.cpu_dtack       (cpu_dtack),
		.sdram_wr        (sdram_wr),
		.sdram_oe        (sdram_oe)
	);

endmodule

// File: verification/tb_ql_bus_glue.sv
//================================================
// QL bus glue testbench
// Directed tests for RAM wrap, QL memory map,
// I/O selects and the GoldCard shadow register
//================================================
`timescale 1ns/1ps
`include "ql_bus_config.svh"

module tb_ql_bus_glue;
	import ql_bus_pkg::*;

	// One fixed pattern per read source
	localparam logic [15:0] ROM_PAT   = 16'hA11A;
	localparam logic [15:0] GC_PAT    = 16'hC66C;
	localparam logic [15:0] SDRAM_PAT = 16'h5D5D;
	localparam logic [15:0] IO_PAT    = 16'h1234;  // Mouse byte is $34
	localparam logic [7:0]  QLSD_PAT  = 8'h96;
	localparam logic [15:0] WR_PAT    = 16'h3CC3;  // CPU write data

	logic        clk_sys;
	logic        reset;
	logic [23:1] cpu_addr_hi;
	logic        cpu_as;
	logic        cpu_rw;
	logic        cpu_uds;
	logic        cpu_lds;
	logic [15:0] cpu_dout;
	ram_cfg_e    ram_cfg_sel;
	logic [15:0] ql_rom_data;
	logic [15:0] gc_rom_data;
	logic [15:0] sdram_data;
	logic [15:0] io_data;
	logic [7:0]  qlsd_data;
	logic        sdram_dtack;
	logic        qlsd_dtack;
	logic        ram_delay_dtack;
	logic [15:0] cpu_din;
	logic        cpu_dtack;
	logic [23:0] sdram_addr;
	logic [15:0] sdram_din;
	logic        sdram_wr;
	logic        sdram_oe;
	logic        vram_wr;
	logic        rom_shadow;
	logic        io_sel;
	logic        qimi_sel;
	logic        zx8302_sel;
	logic        qlsd_sel;
	int          errors;
	int          checks;

	ql_bus_glue UUT
	(
		.clk_sys(clk_sys), .reset(reset), .cpu_addr_hi(cpu_addr_hi), .cpu_as(cpu_as),
		.cpu_rw(cpu_rw), .cpu_uds(cpu_uds), .cpu_lds(cpu_lds), .cpu_dout(cpu_dout),
		.ram_cfg_sel(ram_cfg_sel), .ql_rom_data(ql_rom_data), .gc_rom_data(gc_rom_data),
		.sdram_data(sdram_data), .io_data(io_data), .qlsd_data(qlsd_data),
		.sdram_dtack(sdram_dtack), .qlsd_dtack(qlsd_dtack),
		.ram_delay_dtack(ram_delay_dtack), .cpu_din(cpu_din), .cpu_dtack(cpu_dtack),
		.sdram_addr(sdram_addr), .sdram_din(sdram_din), .sdram_wr(sdram_wr),
		.sdram_oe(sdram_oe), .vram_wr(vram_wr), .rom_shadow(rom_shadow), .io_sel(io_sel),
		.qimi_sel(qimi_sel), .zx8302_sel(zx8302_sel), .qlsd_sel(qlsd_sel)
	);

	always #5 clk_sys = ~clk_sys;  // 10 ns period

	//================================================
	// Check helpers
	//================================================
	task automatic check_word(input string name, input logic [15:0] exp, input logic [15:0] act);
		checks++;
		assert (act === exp)
		else
		begin
			errors++;
			$display("[ERROR] %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		checks++;
		assert (act === exp)
		else
		begin
			errors++;
			$display("[ERROR] %s expected %b actual %b", name, exp, act);
		end
	endtask

	task automatic check_addr(input string name, input logic [23:0] exp, input logic [23:0] act);
		checks++;
		assert (act === exp)
		else
		begin
			errors++;
			$display("[ERROR] %s expected %h actual %h", name, exp, act);
		end
	endtask

	// Polls the shadow flag once per cycle for up to 20 cycles
	task automatic wait_shadow(input logic exp, input string name);
		int cnt;
		cnt = 0;
		while (rom_shadow !== exp && cnt < 20)
		begin
			@(negedge clk_sys);
			cnt++;
		end
		if (rom_shadow !== exp)
		begin
			errors++;
			$display("%s timed out waiting for rom_shadow to become %b", name, exp);
		end
	endtask

	//================================================
	// Bus stimulus on the falling edge
	//================================================
	task automatic drive_bus(input logic [23:0] addr, input logic rw, input logic uds,
		input logic lds);
		@(negedge clk_sys);
		cpu_addr_hi = addr[23:1];
		cpu_as      = 1'b1;
		cpu_rw      = rw;    // 1 reads and 0 writes
		cpu_uds     = uds;
		cpu_lds     = lds;
		#1;                  // Let decode settle
	endtask

	task automatic set_write_data(input logic [15:0] data);
		@(negedge clk_sys);
		cpu_dout = data;
		#1;
	endtask

	task automatic bus_idle();
		@(negedge clk_sys);
		cpu_as  = 1'b0;
		cpu_rw  = 1'b1;
		cpu_uds = 1'b0;
		cpu_lds = 1'b0;
		#1;
	endtask

	task automatic set_acks(input logic sd, input logic qs, input logic dl);
		@(negedge clk_sys);
		sdram_dtack     = sd;
		qlsd_dtack      = qs;
		ram_delay_dtack = dl;
		#1;
	endtask

	// RAM size is captured while reset is high
	task automatic apply_reset(input ram_cfg_e cfg);
		@(negedge clk_sys);
		reset       = 1'b1;
		ram_cfg_sel = cfg;
		cpu_as      = 1'b0;
		cpu_uds     = 1'b0;
		cpu_lds     = 1'b0;
		repeat (4) @(negedge clk_sys);
		reset = 1'b0;
	endtask

	//================================================
	// Directed tests
	//================================================
	task automatic test_ram_wrap();
		apply_reset(ram_128k);
		drive_bus(24'h043002, 1'b1, 1'b1, 1'b1);
		check_addr("test_ram_wrap 128k addr", 24'h001801, sdram_addr);  // Word at $03002
		bus_idle();
		apply_reset(ram_640k);
		drive_bus(24'h140000, 1'b1, 1'b1, 1'b1);  // Wraps onto $040000
		check_addr("test_ram_wrap 640k addr", 24'h020000, sdram_addr);  // Word at $040000
		check_word("test_ram_wrap 640k data", SDRAM_PAT, cpu_din);
		check_bit("test_ram_wrap 640k oe", 1'b1, sdram_oe);
		bus_idle();
	endtask

	task automatic test_ql_map();
		apply_reset(ram_640k);
		set_acks(1'b1, 1'b1, 1'b1);
		drive_bus(24'h001234, 1'b1, 1'b1, 1'b1);
		check_word("test_ql_map rom", ROM_PAT, cpu_din);
		drive_bus(24'h00FEE4, 1'b1, 1'b1, 1'b1);
		check_bit("test_ql_map qlsd_sel", 1'b1, qlsd_sel);
		check_word("test_ql_map qlsd data", {QLSD_PAT, QLSD_PAT}, cpu_din);
		check_bit("test_ql_map qlsd dtack hi", 1'b1, cpu_dtack);
		set_acks(1'b1, 1'b0, 1'b0);
		check_bit("test_ql_map qlsd dtack lo", 1'b0, cpu_dtack);
		drive_bus(24'h030000, 1'b1, 1'b1, 1'b1);  // Base RAM
		check_word("test_ql_map ram data", SDRAM_PAT, cpu_din);
		check_bit("test_ql_map ram dtack", 1'b1, cpu_dtack);
		set_acks(1'b1, 1'b0, 1'b1);
		check_bit("test_ql_map ram delayed", 1'b0, cpu_dtack);
		set_acks(1'b0, 1'b0, 1'b0);
		check_bit("test_ql_map ram sdram busy", 1'b0, cpu_dtack);
		set_acks(1'b1, 1'b0, 1'b0);
		drive_bus(24'h0C0000, 1'b1, 1'b1, 1'b1);  // Nothing mapped above 640k
		check_word("test_ql_map unmapped", `QL_UNMAPPED_DATA, cpu_din);
		bus_idle();
	endtask

	task automatic test_io_selects();
		drive_bus(24'h01BF20, 1'b1, 1'b1, 1'b1);
		check_bit("test_io_selects io_sel mouse", 1'b1, io_sel);
		check_bit("test_io_selects qimi_sel", 1'b1, qimi_sel);
		check_word("test_io_selects mouse", {IO_PAT[7:0], IO_PAT[7:0]}, cpu_din);
		drive_bus(24'h018020, 1'b1, 1'b1, 1'b1);
		check_bit("test_io_selects io_sel zx8302", 1'b1, io_sel);
		check_bit("test_io_selects zx8302_sel", 1'b1, zx8302_sel);
		check_bit("test_io_selects no qimi", 1'b0, qimi_sel);
		check_word("test_io_selects zx8302", IO_PAT, cpu_din);
		set_write_data(WR_PAT);
		drive_bus(24'h020100, 1'b0, 1'b1, 1'b1);  // VRAM page write
		check_bit("test_io_selects vram_wr", 1'b1, vram_wr);
		check_bit("test_io_selects io_sel vram", 1'b0, io_sel);
		check_word("test_io_selects write data", WR_PAT, sdram_din);
		drive_bus(24'h020100, 1'b1, 1'b1, 1'b1);
		check_bit("test_io_selects vram read", 1'b0, vram_wr);
		bus_idle();
		check_bit("test_io_selects vram idle", 1'b0, vram_wr);
	endtask

	task automatic test_gc_boot();
		apply_reset(ram_4096k);
		drive_bus(24'h000100, 1'b1, 1'b1, 1'b1);
		check_word("test_gc_boot low rom", GC_PAT, cpu_din);
		drive_bus(24'h040100, 1'b1, 1'b1, 1'b1);
		check_word("test_gc_boot boot rom", GC_PAT, cpu_din);
		drive_bus(24'h400100, 1'b1, 1'b1, 1'b1);
		check_word("test_gc_boot ql rom", ROM_PAT, cpu_din);
		drive_bus(24'h000100, 1'b0, 1'b1, 1'b1);  // Shadow preload
		check_bit("test_gc_boot preload", 1'b1, sdram_wr);
		drive_bus(24'h00FEE4, 1'b1, 1'b1, 1'b1);
		check_bit("test_gc_boot no qlsd", 1'b0, qlsd_sel);
		bus_idle();
	endtask

	task automatic test_gc_shadow();
		apply_reset(ram_4096k);
		drive_bus(24'h01C060, 1'b0, 1'b1, 1'b0);
		wait_shadow(1'b1, "test_gc_shadow set");
		bus_idle();
		drive_bus(24'h000100, 1'b1, 1'b1, 1'b1);
		check_word("test_gc_shadow os data", SDRAM_PAT, cpu_din);
		check_bit("test_gc_shadow os oe", 1'b1, sdram_oe);
		drive_bus(24'h00C100, 1'b1, 1'b1, 1'b1);
		check_word("test_gc_shadow ext rom", ROM_PAT, cpu_din);
		drive_bus(24'h01C064, 1'b0, 1'b1, 1'b0);
		wait_shadow(1'b0, "test_gc_shadow clear");
		bus_idle();
		drive_bus(24'h01C060, 1'b0, 1'b1, 1'b1);  // Word write is ignored
		repeat (3) @(negedge clk_sys);
		check_bit("test_gc_shadow word write", 1'b0, rom_shadow);
		bus_idle();
		drive_bus(24'h01C060, 1'b0, 1'b1, 1'b0);
		wait_shadow(1'b1, "test_gc_shadow reset");
		bus_idle();
		apply_reset(ram_4096k);
		check_bit("test_gc_shadow after reset", 1'b0, rom_shadow);
	endtask

	initial
	begin
		errors = 0;
		checks = 0;
		clk_sys = 1'b0;
		reset = 1'b1;
		cpu_addr_hi = '0;
		cpu_as = 1'b0;
		cpu_rw = 1'b1;
		cpu_uds = 1'b0;
		cpu_lds = 1'b0;
		cpu_dout = 16'h0000;
		ram_cfg_sel = ram_128k;
		ql_rom_data = ROM_PAT;
		gc_rom_data = GC_PAT;
		sdram_data = SDRAM_PAT;
		io_data = IO_PAT;
		qlsd_data = QLSD_PAT;
		sdram_dtack = 1'b1;
		qlsd_dtack = 1'b1;
		ram_delay_dtack = 1'b0;

		test_ram_wrap();
		test_ql_map();
		test_io_selects();
		test_gc_boot();
		test_gc_shadow();

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: sources.f
+incdir+hdl
hdl/ql_bus_pkg.sv
hdl/ql_addr_decode.sv
hdl/gc_shadow_ctrl.sv
hdl/ql_read_steer.sv
hdl/ql_bus_glue.sv
verification/tb_ql_bus_glue.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the QL bus glue testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps --top-module tb_ql_bus_glue -f sources.f

output=$(./obj_dir/Vtb_ql_bus_glue 2>&1) || true
echo "$output"

if grep -q "=== PASS ===" <<< "$output"; then
	exit 0
fi
echo "Simulation did not pass"
exit 1
